// File: rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0001_0000

// Architectural register count
`define RV_NREGS 32

// ADDI x0,x0,0
`define RV_NOP 32'h0000_0013

`endif

// File: rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        opcode_e             opcode;
        alu_op_e             alu_op;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] rdata1;
        logic [`RV_XLEN-1:0] rdata2;
        logic                reg_write;
        logic                load;
        logic                store;
        logic                bne;    // Branch on not equal
        logic                jump;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic                reg_write;
        logic                load;
        logic                store;
        logic [`RV_XLEN-1:0] result;      // ALU result or data address
        logic [`RV_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic                reg_write;
        logic [`RV_XLEN-1:0] wdata;
    } mem_wb_t;

endpackage

// File: fetch_unit.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] target,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  logic                imem_ack_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    output rv_pkg::if_id_t      if_id
);

    logic [`RV_XLEN-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RV_RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if (redirect) begin
                pc          <= target;  // Drop the word fetched this cycle
                if_id.valid <= 1'b0;
                if_id.instr <= `RV_NOP;
            end else if (!imem_ack_n) begin
                pc          <= pc + `RV_XLEN'd4;
                if_id.valid <= 1'b1;
                if_id.instr <= imem_data;
            end else begin
                // No acknowledge so retry the same address
                if_id.valid <= 1'b0;
                if_id.instr <= `RV_NOP;
            end
            if_id.pc <= pc;
        end
    end

endmodule

// File: decode_unit.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module decode_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  rv_pkg::if_id_t      if_id,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output rv_pkg::id_ex_t      id_ex
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    opcode_e             opc;
    logic [2:0]          funct3;
    logic                is_sub;
    alu_op_e             funct_op;
    id_ex_t              dec;

    assign instr  = if_id.instr;
    assign opc    = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign is_sub = (opc == OP) && instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};

    // Unused source fields read as x0 so they never match a hazard
    assign rs1 = (opc inside {OP, OP_IMM, LOAD, STORE, BRANCH}) ? instr[19:15] : 5'd0;
    assign rs2 = (opc inside {OP, STORE, BRANCH}) ? instr[24:20] : 5'd0;

    always_comb begin
        case (funct3)
            3'b010:  funct_op = ALU_SLT;
            3'b100:  funct_op = ALU_XOR;
            3'b110:  funct_op = ALU_OR;
            3'b111:  funct_op = ALU_AND;
            default: funct_op = is_sub ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.valid  = if_id.valid;
        dec.pc     = if_id.pc;
        dec.opcode = opc;
        dec.alu_op = ALU_ADD;
        dec.rs1    = rs1;
        dec.rs2    = rs2;
        dec.rd     = instr[11:7];
        dec.rdata1 = rdata1;
        dec.rdata2 = rdata2;
        case (opc)
            OP, OP_IMM: begin
                dec.imm       = imm_i;
                dec.alu_op    = funct_op;
                dec.reg_write = 1'b1;
            end
            LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            LOAD: begin
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
                dec.load      = 1'b1;
            end
            STORE: begin
                dec.imm   = imm_s;
                dec.store = 1'b1;
            end
            BRANCH: begin
                dec.imm = imm_b;
                dec.bne = funct3[0];
            end
            JAL: begin
                dec.imm       = imm_j;
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
            end
            default: dec.valid = 1'b0;  // Outside the subset
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= dec;
            if (flush) begin
                id_ex.valid <= 1'b0;
            end
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  rv_pkg::mem_wb_t     wb,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    assign wr_en = wb.valid && wb.reg_write && (wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst && wr_en) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // Same-cycle write is seen by decode
    always_comb begin
        if (rs1 == 5'd0)
            rdata1 = '0;
        else if (wr_en && (wb.rd == rs1))
            rdata1 = wb.wdata;
        else
            rdata1 = regs[rs1];
        if (rs2 == 5'd0)
            rdata2 = '0;
        else if (wr_en && (wb.rd == rs2))
            rdata2 = wb.wdata;
        else
            rdata2 = regs[rs2];
    end

endmodule

// File: execute_unit.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module execute_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  rv_pkg::id_ex_t      id_ex,
    input  rv_pkg::fwd_sel_e    fwd_a,
    input  rv_pkg::fwd_sel_e    fwd_b,
    input  logic [`RV_XLEN-1:0] mem_fwd,
    input  logic [`RV_XLEN-1:0] wb_fwd,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] target,
    output rv_pkg::ex_mem_t     ex_mem
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a, op_b, alu_b, alu_out, result;
    logic                equal;

    function automatic logic [`RV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                    input logic [`RV_XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return mem_fwd;
            FWD_WB:  return wb_fwd;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.rdata1);
    assign op_b  = fwd_mux(fwd_b, id_ex.rdata2);
    assign alu_b = (id_ex.opcode == OP) ? op_b : id_ex.imm;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = op_a + alu_b;
        endcase
    end

    assign result = id_ex.jump ? id_ex.pc + `RV_XLEN'd4 : alu_out;  // Link address

    // BEQ/BNE and JAL share one adder for the target
    assign equal    = (op_a == op_b);
    assign target   = id_ex.pc + id_ex.imm;
    assign redirect = id_ex.valid &&
                      (id_ex.jump || ((id_ex.opcode == BRANCH) && (equal != id_ex.bne)));

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.load       <= id_ex.load;
            ex_mem.store      <= id_ex.store;
            ex_mem.result     <= result;
            ex_mem.store_data <= op_b;
        end
    end

endmodule

// File: mem_access.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module mem_access (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  rv_pkg::ex_mem_t     ex_mem,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    input  logic                dmem_ack_n,
    output logic                dmem_req,
    output logic                dmem_write,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [1:0]          dmem_size,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                mem_busy,
    output logic [`RV_XLEN-1:0] mem_fwd,
    output rv_pkg::mem_wb_t     mem_wb
);

    localparam logic [1:0] size_word = 2'b10;

    logic access;

    assign access = ex_mem.valid && (ex_mem.load || ex_mem.store);

    // Held stable by the global stall until acknowledged
    assign dmem_req   = access;
    assign dmem_write = access && ex_mem.store;
    assign dmem_addr  = ex_mem.result;
    assign dmem_size  = size_word;
    assign dmem_wdata = ex_mem.store_data;

    assign mem_busy = access && dmem_ack_n;

    // Load data only valid in the acknowledge cycle
    assign mem_fwd = ex_mem.load ? dmem_rdata : ex_mem.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else if (!stall) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wdata     <= mem_fwd;
        end
    end

endmodule

// File: pipe_control.sv
`timescale 1ns/10ps

module pipe_control (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::if_id_t   if_id,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_mem_t  ex_mem,
    input  rv_pkg::mem_wb_t  mem_wb,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic             redirect,
    input  logic             mem_busy,
    output logic             stall_if,
    output logic             stall_id,
    output logic             stall_ex,
    output logic             flush_id,
    output logic             flush_ex,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b
);

    import rv_pkg::*;

    logic load_use;
    logic lu_q;  // Bubble inserted last cycle

    // Youngest producer wins
    function automatic fwd_sel_e pick(input logic [4:0] src, input ex_mem_t em,
                                      input mem_wb_t mw);
        if (src != 5'd0 && em.valid && em.reg_write && em.rd == src)
            return FWD_MEM;
        if (src != 5'd0 && mw.valid && mw.reg_write && mw.rd == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = pick(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick(id_ex.rs2, ex_mem, mem_wb);

    assign load_use = id_ex.valid && id_ex.load && (id_ex.rd != 5'd0) && if_id.valid &&
                      !lu_q && ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    always_ff @(posedge clk) begin
        if (rst)
            lu_q <= 1'b0;
        else
            lu_q <= load_use && !mem_busy;
    end

    // Data bus wait freezes every stage register
    assign stall_if = mem_busy || load_use;
    assign stall_id = mem_busy;
    assign stall_ex = mem_busy;

    assign flush_id = redirect;
    assign flush_ex = redirect || load_use;  // Bubble into ID/EX

endmodule

// File: rv_core.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst,

    // Instruction bus
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  logic                imem_ack_n,  // Low when imem_data is valid

    // Data bus
    output logic                dmem_req,
    output logic                dmem_write,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [1:0]          dmem_size,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    input  logic                dmem_ack_n   // Low completes the access
);

    import rv_pkg::*;

    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    mem_wb_t             mem_wb;
    logic [4:0]          rs1, rs2;
    logic [`RV_XLEN-1:0] rdata1, rdata2;
    logic                stall_if, stall_id, stall_ex;
    logic                flush_id, flush_ex;
    fwd_sel_e            fwd_a, fwd_b;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
    logic                mem_busy;
    logic [`RV_XLEN-1:0] mem_fwd;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall_if),
        .redirect   (flush_id),
        .target     (target),
        .imem_data  (imem_data),
        .imem_ack_n (imem_ack_n),
        .imem_addr  (imem_addr),
        .if_id      (if_id)
    );

    decode_unit u_decode (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall_id),
        .flush  (flush_ex),
        .if_id  (if_id),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rs1    (rs1),
        .rs2    (rs2),
        .id_ex  (id_ex)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .wb     (mem_wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_unit u_execute (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall_ex),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (mem_wb.wdata),
        .redirect (redirect),
        .target   (target),
        .ex_mem   (ex_mem)
    );

    mem_access u_mem (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall_ex),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_ack_n (dmem_ack_n),
        .dmem_req   (dmem_req),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_size  (dmem_size),
        .dmem_wdata (dmem_wdata),
        .mem_busy   (mem_busy),
        .mem_fwd    (mem_fwd),
        .mem_wb     (mem_wb)
    );

    pipe_control u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .rs1      (rs1),
        .rs2      (rs2),
        .redirect (redirect),
        .mem_busy (mem_busy),
        .stall_if (stall_if),
        .stall_id (stall_id),
        .stall_ex (stall_ex),
        .flush_id (flush_id),
        .flush_ex (flush_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

endmodule

// File: rv_checker.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_checker (
    input logic                clk,
    input logic                rst,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic                dmem_req,
    input logic                dmem_write,
    input logic [`RV_XLEN-1:0] dmem_addr,
    input logic [1:0]          dmem_size,
    input logic [`RV_XLEN-1:0] dmem_wdata,
    input logic                dmem_ack_n
);

    logic [`RV_XLEN-1:0] exp_addr [$];
    logic [`RV_XLEN-1:0] exp_data [$];
    int                  seen = 0;
    int                  errors = 0;

    task automatic clear();
        exp_addr.delete();
        exp_data.delete();
        seen = 0;
    endtask

    task automatic expect_store(input logic [`RV_XLEN-1:0] addr,
                                input logic [`RV_XLEN-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_reset();
        if (imem_addr !== `RV_RESET_PC) begin
            $display("** Error imem_addr: expected %h, got %h", `RV_RESET_PC, imem_addr);
            errors++;
        end
        if (dmem_req !== 1'b0 || dmem_write !== 1'b0) begin
            $display("** Error dmem_req/dmem_write: expected 0/0, got %h/%h",
                     dmem_req, dmem_write);
            errors++;
        end
    endtask

    // A store completes in the acknowledge cycle
    always @(posedge clk) begin
        if (!rst && dmem_req && !dmem_ack_n && dmem_size !== 2'b10) begin
            $display("** Error dmem_size: expected %h, got %h", 2'b10, dmem_size);
            errors++;
        end
        if (!rst && dmem_req && dmem_write && !dmem_ack_n) begin
            if (seen >= exp_addr.size()) begin
                $display("Unexpected store to %h with data %h", dmem_addr, dmem_wdata);
                errors++;
            end else begin
                if (dmem_addr !== exp_addr[seen]) begin
                    $display("** Error dmem_addr: expected %h, got %h", exp_addr[seen], dmem_addr);
                    errors++;
                end
                if (dmem_wdata !== exp_data[seen]) begin
                    $display("** Error dmem_wdata: expected %h, got %h",
                             exp_data[seen], dmem_wdata);
                    errors++;
                end
            end
            seen++;
        end
    end

endmodule

// File: rv_properties.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_properties (
    input logic                clk,
    input logic                rst,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic                dmem_req,
    input logic                dmem_write,
    input logic [`RV_XLEN-1:0] dmem_addr,
    input logic [`RV_XLEN-1:0] dmem_wdata,
    input logic                dmem_ack_n
);

    // Waiting request keeps its fields
    req_stable: assert property (@(posedge clk) disable iff (rst)
        dmem_req && dmem_ack_n |=> dmem_req && $stable(dmem_addr) &&
                                   $stable(dmem_write) && $stable(dmem_wdata))
        else $error("data bus request changed before its acknowledge");

    write_needs_req: assert property (@(posedge clk) disable iff (rst)
        !(dmem_write && !dmem_req))
        else $error("dmem_write high without dmem_req");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

endmodule

bind rv_core rv_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .dmem_write (dmem_write),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_ack_n (dmem_ack_n)
);

// File: tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam int prog_words   = 64;
    localparam int body_start   = 7;
    localparam int epilogue     = 47;  // Seven stores of x1..x7 and the self loop
    localparam int drain_cycles = 40;
    localparam int run_timeout  = 3000;

    logic                clk = 1'b0;
    logic                rst;
    logic [`RV_XLEN-1:0] imem_addr, imem_data;
    logic                imem_ack_n;
    logic                dmem_req, dmem_write, dmem_ack_n;
    logic [`RV_XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic [1:0]          dmem_size;

    logic [31:0] imem [prog_words];
    logic [31:0] dmem [64];
    logic [31:0] dmem_init [64];
    integer      seed = 2327;
    logic        delays_on;
    int          imem_wait, dmem_wait;
    int          tests_run, tests_failed;

    always #2 clk = ~clk;

    rv_core dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .imem_ack_n (imem_ack_n),
        .dmem_req   (dmem_req),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_size  (dmem_size),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_ack_n (dmem_ack_n)
    );

    rv_checker chk (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_size  (dmem_size),
        .dmem_wdata (dmem_wdata),
        .dmem_ack_n (dmem_ack_n)
    );

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `RV_RESET_PC;
        if (off < 32'd256)
            return imem[off[7:2]];
        return `RV_NOP;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Instruction and data memories answer on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            imem_ack_n = 1'b1;
            dmem_ack_n = 1'b1;
            imem_wait  = 0;
            dmem_wait  = 0;
        end else begin
            if (imem_wait == 0) begin
                imem_ack_n = 1'b0;
                imem_data  = fetch_word(imem_addr);
                imem_wait  = delays_on ? ($random(seed) & 3) : 0;
            end else begin
                imem_ack_n = 1'b1;
                imem_wait  = imem_wait - 1;
            end
            if (dmem_req && dmem_wait == 0) begin
                dmem_ack_n = 1'b0;
                dmem_rdata = dmem[dmem_addr[7:2]];
                if (dmem_write)
                    dmem[dmem_addr[7:2]] = dmem_wdata;
                dmem_wait = delays_on ? ($random(seed) & 3) : 0;
            end else if (dmem_req) begin
                dmem_ack_n = 1'b1;
                dmem_wait  = dmem_wait - 1;
            end else begin
                dmem_ack_n = 1'b1;
            end
        end
    end

    // Random program with register setup, body, closing stores and self loop
    task automatic build_program(input int kind);
        logic [31:0] r;
        logic [4:0]  rd, ra, rb, last_rd;
        logic [2:0]  f3;
        int          pick, cat, k;
        for (int i = 0; i < prog_words; i++)
            imem[i] = `RV_NOP;
        for (int i = 1; i < 8; i++) begin
            r = $random(seed);
            imem[i-1] = i_type(r[11:0], 5'd0, 3'd0, 5'(i), OP_IMM);
        end
        last_rd = 5'd7;
        for (int i = body_start; i < epilogue; i++) begin
            r    = $random(seed);
            rd   = (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
            ra   = {2'b00, r[5:3]};
            rb   = {2'b00, r[8:6]};
            pick = int'(r[12:9]);
            if (r[16])
                ra = last_rd;  // Back-to-back dependency
            if (r[17])
                rb = last_rd;
            case (kind)
                2:       cat = (pick < 6) ? 0 : (pick < 11) ? 1 : (pick < 12) ? 2 : 4;
                3:       cat = (pick < 5) ? 3 : (pick < 9) ? 0 : (pick < 12) ? 1 : 4;
                4:       cat = (pick < 4) ? 5 : (pick < 6) ? 6 : (pick < 11) ? 0 : 4;
                default: cat = pick % 7;
            endcase
            k = 2 + int'(r[14:13]);
            if (i + k > epilogue)
                k = epilogue - i;
            case (cat)
                0: begin
                    case (r[15:13])
                        3'd1:    imem[i] = r_type(7'h20, rb, ra, 3'd0, rd);
                        3'd2:    imem[i] = r_type(7'h00, rb, ra, 3'd2, rd);
                        3'd3:    imem[i] = r_type(7'h00, rb, ra, 3'd4, rd);
                        3'd4:    imem[i] = r_type(7'h00, rb, ra, 3'd6, rd);
                        3'd5:    imem[i] = r_type(7'h00, rb, ra, 3'd7, rd);
                        default: imem[i] = r_type(7'h00, rb, ra, 3'd0, rd);
                    endcase
                end
                1: begin
                    case (r[14:13])
                        2'd0:    f3 = 3'd0;
                        2'd1:    f3 = 3'd4;
                        2'd2:    f3 = 3'd6;
                        default: f3 = 3'd7;
                    endcase
                    imem[i] = i_type(r[31:20], ra, f3, rd, OP_IMM);
                end
                2: imem[i] = {r[31:12], rd, LUI};
                3: imem[i] = i_type(r[31:20], ra, 3'd2, rd, LOAD);
                4: imem[i] = s_type(r[31:20], rb, ra);
                5: imem[i] = b_type(13'(4 * k), rb, ra, {2'b00, r[15]});
                default: imem[i] = j_type(21'(4 * k), rd);
            endcase
            if (cat inside {0, 1, 2, 3, 6})
                last_rd = rd;
        end
        for (int i = 1; i < 8; i++)
            imem[epilogue+i-1] = s_type(12'(4 * i), 5'(i), 5'd0);
        imem[epilogue+7] = j_type(21'd0, 5'd0);
    endtask

    // Architectural reference run that hands the expected stores to the checker
    task automatic run_model(output int n);
        logic [31:0] x [32];
        logic [31:0] mem [64];
        logic [31:0] pc, ins, a, b, res, nxt, addr, imm_i;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = dmem_init[i];
        pc    = `RV_RESET_PC;
        n     = 0;
        steps = 0;
        while (steps < 1000) begin
            ins = fetch_word(pc);
            if (ins == 32'h0000_006f)
                break;
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            nxt   = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                OP, OP_IMM: begin
                    if (ins[6:0] == OP_IMM)
                        b = imm_i;
                    case (ins[14:12])
                        3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4:    res = a ^ b;
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: res = (ins[6:0] == OP && ins[30]) ? a - b : a + b;
                    endcase
                end
                LUI:  res = {ins[31:12], 12'd0};
                LOAD: begin
                    addr = a + imm_i;
                    res  = mem[addr[7:2]];
                end
                STORE: begin
                    wr   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[7:2]] = b;
                    chk.expect_store(addr, b);
                    n++;
                end
                BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12])
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                JAL: begin
                    res = pc + 32'd4;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0)
                x[ins[11:7]] = res;
            pc = nxt;
            steps++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        for (int i = 0; i < 10; i++)
            @(negedge clk);
        chk.check_reset();
        rst = 1'b0;
    endtask

    task automatic run_test(input int kind, input string name);
        int expected, waited, errs_before;
        logic ok;
        build_program(kind);
        for (int i = 0; i < 64; i++) begin
            dmem_init[i] = $random(seed);
            dmem[i]      = dmem_init[i];
        end
        chk.clear();
        run_model(expected);
        delays_on   = (kind == 5);
        errs_before = chk.errors;
        ok          = 1'b1;
        apply_reset();
        waited = 0;
        while (chk.seen < expected && waited < run_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (chk.seen < expected) begin
            $display("Timeout in %s: saw %0d of %0d stores", name, chk.seen, expected);
            ok = 1'b0;
        end
        for (int i = 0; i < drain_cycles; i++)
            @(negedge clk);
        if (chk.seen != expected) begin
            $display("Store count in %s is %0d, model count is %0d", name, chk.seen, expected);
            ok = 1'b0;
        end
        if (chk.errors != errs_before)
            ok = 1'b0;
        tests_run++;
        if (!ok)
            tests_failed++;
        $display("Test %0d %s: %s (%0d stores)", kind, name, ok ? "ok" : "FAILED", expected);
    endtask

    initial begin
        rst          = 1'b1;
        imem_data    = `RV_NOP;
        imem_ack_n   = 1'b1;
        dmem_rdata   = '0;
        dmem_ack_n   = 1'b1;
        delays_on    = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        begin : reset_test
            int errs_before;
            errs_before = chk.errors;
            apply_reset();
            tests_run++;
            if (chk.errors != errs_before)
                tests_failed++;
            $display("Test 1 reset_state: %s", (chk.errors == errs_before) ? "ok" : "FAILED");
        end
        run_test(2, "alu_forwarding");
        run_test(3, "load_use");
        run_test(4, "branch_jump");
        run_test(5, "ack_delays");
        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 chk.errors);
        if (tests_failed == 0 && chk.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
rv_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
mem_access.sv
pipe_control.sv
rv_core.sv
rv_checker.sv
rv_properties.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
